// File: branch_predecode.sv
`timescale 1ns/100ps
`default_nettype none

module branch_predecode import fetch_pkg::*; (
	input  addr_t pc,
	input  inst_t inst,
	output logic  pred_taken,
	output addr_t pred_target
);

	// ********************
	// opcode decode
	logic  is_jal;
	logic  is_branch;
	addr_t imm_j;
	addr_t imm_b;

	always_comb begin
		is_jal    = 1'b0;
		is_branch = 1'b0;
		if (inst[6:0] == 7'b1101111) begin
			is_jal = 1'b1;
		end else if (inst[6:0] == 7'b1100011) begin
			// funct3 010 and 011 are not defined for branches
			case (inst[14:12])
				3'b000, 3'b001, 3'b100,
				3'b101, 3'b110, 3'b111: is_branch = 1'b1;
				default:                is_branch = 1'b0;
			endcase
		end
	end

	// ********************
	// immediates, sign taken from bit 31
	// j-type offset
	assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
	// b-type offset
	assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

	// ********************
	// static prediction
	// jal always taken
	// conditional branch taken only when the offset points backward
	assign pred_taken = is_jal || (is_branch && inst[31]);

	// target only matters when pred_taken is high
	assign pred_target = pc + (is_jal ? imm_j : imm_b);

endmodule

`default_nettype wire

// File: fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// ********************
// fetch address after reset
`define FETCH_RESET_PC 64'h0000_0000_8000_0000

// ********************
// instruction cache geometry
`define ICACHE_SETS 16
`define ICACHE_LINE_WORDS 4
// log2 of the two sizes above
`define ICACHE_INDEX_BITS 4
`define ICACHE_WORD_BITS 2

// ********************
// backing memory image in words, addresses wrap inside it
`define IMAGE_WORDS 1024

`endif

// File: fetch_pkg.sv
`default_nettype none

`include "fetch_defs.svh"

package fetch_pkg;

	// byte address as seen by the core
	typedef logic [63:0] addr_t;

	// one rv64 base instruction
	typedef logic [31:0] inst_t;

	// whole cache line, word 0 sits in the low bits
	typedef logic [32*`ICACHE_LINE_WORDS-1:0] line_t;

	// set select taken from the pc
	typedef logic [`ICACHE_INDEX_BITS-1:0] index_t;

	// pc bits above index and word offset
	typedef logic [61-`ICACHE_WORD_BITS-`ICACHE_INDEX_BITS:0] tag_t;

	// miss handling states
	typedef enum logic {
		LOOKUP = 1'b0,
		REFILL = 1'b1
	} icache_state_t;

endpackage

`default_nettype wire

// File: fetch_props.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_props import fetch_pkg::*; (
	input logic  clk,
	input logic  rst,
	input logic  fetch_valid,
	input logic  fetch_ready,
	input addr_t fetch_pc,
	input inst_t fetch_inst,
	input logic  redirect_valid,
	input logic  mem_req,
	input addr_t mem_addr,
	input logic  mem_valid
);

	// failed assertion count polled by the testbench
	int fail_count = 0;

	// ********************
	// reset
	// nothing offered or requested after a reset edge
	reset_quiet: assert property (@(posedge clk) rst |=> !fetch_valid && !mem_req)
		else begin
			$error("fetch_valid or mem_req high after reset");
			fail_count = fail_count + 1;
		end

	// ********************
	// decode handshake
	// stalled word holds
	// valid only drops for a redirect
	stall_hold: assert property (@(posedge clk) disable iff (rst)
		fetch_valid && !fetch_ready |=> (fetch_valid || redirect_valid)
			&& $stable(fetch_pc) && $stable(fetch_inst))
		else begin
			$error("fetch output changed under stall");
			fail_count = fail_count + 1;
		end

	// ********************
	// refill port
	// request and address held until the response
	req_hold: assert property (@(posedge clk) disable iff (rst)
		mem_req && !mem_valid |=> mem_req && $stable(mem_addr))
		else begin
			$error("mem_req or mem_addr changed before mem_valid");
			fail_count = fail_count + 1;
		end

endmodule

`default_nettype wire

// File: fetch_unit.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_unit import fetch_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	// decode side
	output logic  fetch_valid,
	input  logic  fetch_ready,
	output addr_t fetch_pc,
	output inst_t fetch_inst,
	output logic  fetch_pred_taken,
	// redirect from later stages
	input  logic  redirect_valid,
	input  addr_t redirect_pc,
	// line refill port
	output logic  mem_req,
	output addr_t mem_addr,
	input  logic  mem_valid,
	input  line_t mem_line
);

	// ********************
	// internal nets
	logic  cache_hit;
	addr_t pred_target;

	// pc register and next address
	pc_gen u_pc_gen (
		.clk            (clk),
		.rst            (rst),
		.hit            (cache_hit),
		.fetch_ready    (fetch_ready),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.pred_taken     (fetch_pred_taken),
		.pred_target    (pred_target),
		.pc             (fetch_pc),
		.fetch_valid    (fetch_valid)
	);

	// direct mapped cache, looked up with the current pc
	icache u_icache (
		.clk       (clk),
		.rst       (rst),
		.pc        (fetch_pc),
		.hit       (cache_hit),
		.inst      (fetch_inst),
		.mem_req   (mem_req),
		.mem_addr  (mem_addr),
		.mem_valid (mem_valid),
		.mem_line  (mem_line)
	);

	// static prediction on the word coming out of the cache
	branch_predecode u_branch_predecode (
		.pc          (fetch_pc),
		.inst        (fetch_inst),
		.pred_taken  (fetch_pred_taken),
		.pred_target (pred_target)
	);

endmodule

`default_nettype wire

// File: filelist.f
+incdir+.
fetch_pkg.sv
branch_predecode.sv
pc_gen.sv
icache.sv
fetch_unit.sv
fetch_props.sv
tb_fetch.sv

// File: icache.sv
`timescale 1ns/100ps
`default_nettype none

`include "fetch_defs.svh"

module icache import fetch_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	// lookup side
	input  addr_t pc,
	output logic  hit,
	output inst_t inst,
	// refill port to memory
	output logic  mem_req,
	output addr_t mem_addr,
	input  logic  mem_valid,
	input  line_t mem_line
);

	// ********************
	// storage
	// one valid bit per set
	logic [`ICACHE_SETS-1:0] valid_q;
	tag_t                    tag_q  [`ICACHE_SETS];
	line_t                   data_q [`ICACHE_SETS];

	icache_state_t state_q;

	// ********************
	// pc fields
	// bits 1:0 are the byte offset inside a word
	logic [`ICACHE_WORD_BITS-1:0] lookup_word;
	index_t                       lookup_index;
	tag_t                         lookup_tag;
	line_t                        lookup_line;

	assign lookup_word  = pc[2 +: `ICACHE_WORD_BITS];
	assign lookup_index = pc[2+`ICACHE_WORD_BITS +: `ICACHE_INDEX_BITS];
	assign lookup_tag   = pc[63:2+`ICACHE_WORD_BITS+`ICACHE_INDEX_BITS];

	// ********************
	// hit detection
	// lookups only count while no refill is running
	assign hit = (state_q == LOOKUP)
		&& valid_q[lookup_index]
		&& (tag_q[lookup_index] == lookup_tag);

	// word select inside the line
	assign lookup_line = data_q[lookup_index];
	assign inst        = lookup_line[{lookup_word, 5'd0} +: 32];

	// ********************
	// refill control
	logic   miss;
	logic   fill;
	index_t refill_index;
	tag_t   refill_tag;

	// miss only seen in LOOKUP
	assign miss = (state_q == LOOKUP) && !hit;

	// line arrives this cycle
	assign fill = (state_q == REFILL) && mem_valid;

	// set and tag of the pending line come back out of the request address
	assign refill_index = mem_addr[2+`ICACHE_WORD_BITS +: `ICACHE_INDEX_BITS];
	assign refill_tag   = mem_addr[63:2+`ICACHE_WORD_BITS+`ICACHE_INDEX_BITS];

	// request is up for the whole REFILL state
	// rises the cycle after the miss
	// drops on the edge after mem_valid
	assign mem_req = (state_q == REFILL);

	// miss fsm and valid bits
	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= LOOKUP;
			valid_q <= '0;
		end else begin
			case (state_q)
				LOOKUP: begin
					if (miss) begin
						state_q <= REFILL;
					end
				end
				REFILL: begin
					// latency varies, wait for the response pulse
					if (mem_valid) begin
						state_q               <= LOOKUP;
						valid_q[refill_index] <= 1'b1;
					end
				end
				default: begin
					state_q <= LOOKUP;
				end
			endcase
		end
	end

	// ********************
	// request address and array writes
	always_ff @(posedge clk) begin
		// line aligned address of the missing pc
		// stays put until the line comes back
		if (miss) begin
			mem_addr <= {lookup_tag, lookup_index, {(2+`ICACHE_WORD_BITS){1'b0}}};
		end
		// whole line written at once
		// hit shows up on the next cycle
		if (fill) begin
			data_q[refill_index] <= mem_line;
			tag_q[refill_index]  <= refill_tag;
		end
	end

endmodule

`default_nettype wire

// File: pc_gen.sv
`timescale 1ns/100ps
`default_nettype none

`include "fetch_defs.svh"

module pc_gen import fetch_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	// cache lookup result for the current pc
	input  logic  hit,
	// decode handshake
	input  logic  fetch_ready,
	// redirect from later stages
	input  logic  redirect_valid,
	input  addr_t redirect_pc,
	// predecode of the current word
	input  logic  pred_taken,
	input  addr_t pred_target,
	output addr_t pc,
	output logic  fetch_valid
);

	logic  transfer;
	addr_t seq_pc;
	addr_t next_pc;

	// ********************
	// decode handshake
	// word is offered as soon as the cache hits
	// a redirect kills the offer in the same cycle
	assign fetch_valid = hit && !redirect_valid;

	// instruction accepted by decode
	assign transfer = fetch_valid && fetch_ready;

	// fall through address
	assign seq_pc = pc + 64'd4;

	// ********************
	// next address select
	always_comb begin
		if (redirect_valid) begin
			// redirect beats any prediction
			next_pc = redirect_pc;
		end else if (transfer) begin
			// jal or backward branch goes to target
			next_pc = pred_taken ? pred_target : seq_pc;
		end else begin
			// stall or miss
			// hold so pc and word stay stable for decode
			next_pc = pc;
		end
	end

	// program counter register
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= `FETCH_RESET_PC;
		end else begin
			pc <= next_pc;
		end
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the fetch unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_fetch -f filelist.f -o tb_fetch_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

# let assertion errors reach the testbench instead of stopping at the first one
out=$(./obj_dir/tb_fetch_sim +verilator+error+limit+100)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "Simulation finished: PASS"; then
	exit 0
fi
exit 1

// File: tb_fetch.sv
`timescale 1ns/100ps
`default_nettype none

`include "fetch_defs.svh"

module tb_fetch import fetch_pkg::*; ();

	// ********************
	// run length
	localparam int MAX_TRANSFERS = 3000;
	// about a dozen cycles per instruction covers misses, stalls and redirects
	localparam int CYCLE_LIMIT   = MAX_TRANSFERS * 12;

	logic  clk;
	logic  rst;
	logic  fetch_valid;
	logic  fetch_ready;
	addr_t fetch_pc;
	inst_t fetch_inst;
	logic  fetch_pred_taken;
	logic  redirect_valid;
	addr_t redirect_pc;
	logic  mem_req;
	addr_t mem_addr;
	logic  mem_valid;
	line_t mem_line;

	// program image plus the prediction each word should give
	inst_t image     [`IMAGE_WORDS];
	logic  img_taken [`IMAGE_WORDS];
	addr_t img_off   [`IMAGE_WORDS];

	logic [31:0] lfsr;
	addr_t       exp_pc;

	fetch_unit UUT (
		.clk              (clk),
		.rst              (rst),
		.fetch_valid      (fetch_valid),
		.fetch_ready      (fetch_ready),
		.fetch_pc         (fetch_pc),
		.fetch_inst       (fetch_inst),
		.fetch_pred_taken (fetch_pred_taken),
		.redirect_valid   (redirect_valid),
		.redirect_pc      (redirect_pc),
		.mem_req          (mem_req),
		.mem_addr         (mem_addr),
		.mem_valid        (mem_valid),
		.mem_line         (mem_line)
	);

	// handshake and refill rules checked inside the DUT
	bind fetch_unit fetch_props props_chk (
		.clk            (clk),
		.rst            (rst),
		.fetch_valid    (fetch_valid),
		.fetch_ready    (fetch_ready),
		.fetch_pc       (fetch_pc),
		.fetch_inst     (fetch_inst),
		.redirect_valid (redirect_valid),
		.mem_req        (mem_req),
		.mem_addr       (mem_addr),
		.mem_valid      (mem_valid)
	);

	always #5 clk = ~clk;

	// ********************
	// random source
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		// galois form, taps 32 22 2 1
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	// one lfsr step per bit, newest bit lowest
	task automatic get_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// jal about 1 in 8, branch about 1 in 6, rest alu
	task automatic make_word(output inst_t w, output logic tk, output addr_t off);
		logic [31:0] kind;
		logic [31:0] mag;
		logic [31:0] neg;
		logic [31:0] f3;
		logic [31:0] regs;
		addr_t       imm;
		get_bits(8, kind);
		get_bits(5, mag);
		get_bits(1, neg);
		get_bits(3, f3);
		get_bits(25, regs);
		// offset of 1 to 32 words, either sign
		imm = (64'(mag[4:0]) + 64'd1) * 64'd4;
		if (neg[0]) begin
			imm = -imm;
		end
		off = imm;
		if (kind[7:0] < 8'd32) begin
			w  = {imm[20], imm[10:1], imm[11], imm[19:12], regs[4:0], 7'b1101111};
			tk = 1'b1;
		end else if (kind[7:0] < 8'd75) begin
			w  = {imm[12], imm[10:5], regs[14:10], regs[9:5], f3[2:0], imm[4:1], imm[11],
				7'b1100011};
			// funct3 010 and 011 are no branch at all
			tk = neg[0] && (f3[2:0] != 3'b010) && (f3[2:0] != 3'b011);
		end else begin
			w  = {regs[24:0], 7'b0110011};
			tk = 1'b0;
		end
	endtask

	// ********************
	// memory model, wraps inside the image
	function automatic int word_index(input addr_t a);
		return int'((a >> 2) % `IMAGE_WORDS);
	endfunction

	function automatic line_t build_line(input addr_t a);
		line_t l;
		for (int w = 0; w < `ICACHE_LINE_WORDS; w++) begin
			l[32*w +: 32] = image[word_index(a + 64'(4 * w))];
		end
		return l;
	endfunction

	// ********************
	// checking
	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	initial begin
		int          idx;
		int          transfers;
		int          cycles;
		int          wait_cnt;
		logic        pending;
		logic        stalled;
		addr_t       held_addr;
		logic [31:0] r;
		clk            = 1'b0;
		rst            = 1'b1;
		fetch_ready    = 1'b0;
		redirect_valid = 1'b0;
		redirect_pc    = '0;
		mem_valid      = 1'b0;
		mem_line       = '0;
		lfsr           = 32'h2f0b;
		transfers      = 0;
		cycles         = 0;
		wait_cnt       = 0;
		pending        = 1'b0;
		stalled        = 1'b0;
		held_addr      = '0;
		exp_pc         = `FETCH_RESET_PC;
		for (int i = 0; i < `IMAGE_WORDS; i++) begin
			make_word(image[i], img_taken[i], img_off[i]);
		end

		// reset held for 4 edges, outputs quiet once reset is seen
		repeat (3) begin
			@(posedge clk);
			@(negedge clk);
			check_value("mem_req", mem_req, 64'd0);
			check_value("fetch_valid", fetch_valid, 64'd0);
		end
		@(posedge clk);
		#1;
		rst = 1'b0;
		// first lookup misses, request comes one cycle later
		@(negedge clk);
		check_value("mem_req", mem_req, 64'd0);
		check_value("fetch_valid", fetch_valid, 64'd0);
		check_value("fetch_pc", fetch_pc, exp_pc);

		while (transfers < MAX_TRANSFERS) begin
			@(posedge clk);
			#1;
			cycles++;
			if (cycles > CYCLE_LIMIT) begin
				fail_run("timeout: too few instructions reached decode");
			end
			// decode back-pressure, ready about 3 of 4 cycles
			get_bits(2, r);
			fetch_ready = (r[1:0] != 2'b00);
			// redirect roughly once per 40 cycles
			get_bits(8, r);
			redirect_valid = (r[7:0] < 8'd6);
			get_bits(12, r);
			// 4096 words, so targets alias in the 1024 word image
			redirect_pc = `FETCH_RESET_PC + {50'd0, r[11:0], 2'b00};

			// ********************
			// memory responder, 1 to 8 cycles
			mem_valid = 1'b0;
			if (mem_req) begin
				if (!pending) begin
					check_value("mem_addr offset", mem_addr % (4 * `ICACHE_LINE_WORDS), 64'd0);
					pending   = 1'b1;
					held_addr = mem_addr;
					get_bits(3, r);
					wait_cnt  = int'(r[2:0]);
				end else begin
					check_value("mem_addr", mem_addr, held_addr);
				end
				if (wait_cnt == 0) begin
					mem_valid = 1'b1;
					mem_line  = build_line(held_addr);
					pending   = 1'b0;
				end else begin
					wait_cnt--;
				end
			end else if (pending) begin
				fail_run("mem_req dropped before the line was returned");
			end

			// outputs settled, compare with the model
			@(negedge clk);
			if (UUT.props_chk.fail_count != 0) begin
				fail_run("a bound assertion on the fetch unit failed");
			end
			// pc only moves on transfer or redirect
			check_value("fetch_pc", fetch_pc, exp_pc);
			if (redirect_valid) begin
				check_value("fetch_valid", fetch_valid, 64'd0);
				exp_pc  = redirect_pc;
				stalled = 1'b0;
			end else begin
				// offered word must stay offered under stall
				if (stalled) begin
					check_value("fetch_valid", fetch_valid, 64'd1);
				end
				if (fetch_valid) begin
					idx = word_index(fetch_pc);
					check_value("fetch_inst", fetch_inst, image[idx]);
					check_value("fetch_pred_taken", fetch_pred_taken, img_taken[idx]);
					if (fetch_ready) begin
						exp_pc = img_taken[idx] ? exp_pc + img_off[idx] : exp_pc + 64'd4;
						transfers++;
					end
				end
				stalled = fetch_valid && !fetch_ready;
			end
		end
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire
